/* via_config.svh */
// VIA configuration: bus and timer widths, register map and control bit positions
`ifndef VIA_CONFIG_SVH
`define VIA_CONFIG_SVH

`define VIA_DW 32 // bus data width
`define VIA_TW 32 // timer width

// ======================================================================
// register indices, 5 7 and 10 are reserved
// ======================================================================
`define VIA_REG_PB   4'd0
`define VIA_REG_PA   4'd1
`define VIA_REG_DDRB 4'd2
`define VIA_REG_DDRA 4'd3
`define VIA_REG_T1CL 4'd4
`define VIA_REG_T1LL 4'd6
`define VIA_REG_T2CL 4'd8
`define VIA_REG_T2LL 4'd9
`define VIA_REG_ACR  4'd11
`define VIA_REG_PCR  4'd12
`define VIA_REG_IFR  4'd13
`define VIA_REG_IER  4'd14
`define VIA_REG_ORA  4'd15

// ACR fields
`define VIA_ACR_PA_LE   0
`define VIA_ACR_PB_LE   1
`define VIA_ACR_T2_CNT  5 // count pb6 falling edges
`define VIA_ACR_T1_FREE 6

// PCR fields, 1 selects the rising edge
`define VIA_PCR_CA1_POL 0
`define VIA_PCR_CA2_POL 1
`define VIA_PCR_CB1_POL 4
`define VIA_PCR_CB2_POL 5

// IFR / IER layout
`define VIA_IFR_CA2 0
`define VIA_IFR_CA1 1
`define VIA_IFR_CB2 3
`define VIA_IFR_CB1 4
`define VIA_IFR_T1  5
`define VIA_IFR_T2  6
`define VIA_IFR_IRQ 7 // any enabled flag set

`endif

/* via_pkg.sv */
// VIA shared types: bus words, timer values, register strobes and bus FSM states
`include "via_config.svh"

package via_pkg;

	typedef logic [`VIA_DW-1:0] data_t;
	typedef logic [`VIA_TW-1:0] timer_t;
	typedef logic [3:0]         reg_adr_t;
	typedef logic [15:0]        reg_strb_t; // one-hot, bit n for register n
	typedef logic [3:0]         byte_sel_t;
	typedef logic [7:0]         irq_vec_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_RD1,  // read mux stage
		BUS_RD2,  // read data out, ack high
		BUS_ACK   // write ack
	} bus_state_e;

	// merge selected byte lanes of new_v into old_v
	function automatic data_t byte_merge(input data_t old_v, input data_t new_v,
		input byte_sel_t sel);
		data_t res;
		res = old_v;
		for (int i = 0; i < 4; i++)
			if (sel[i]) res[i*8 +: 8] = new_v[i*8 +: 8];
		return res;
	endfunction

endpackage

/* via_bus_slave.sv */
// VIA bus slave with register decode, one-cycle strobes, read mux, ACR/PCR and acknowledge
`timescale 1ns/1ns
`include "via_config.svh"

module via_bus_slave (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 cs_i,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  via_pkg::byte_sel_t   sel_i,
	input  via_pkg::reg_adr_t    adr_i,
	input  via_pkg::data_t       dat_i,
	output via_pkg::data_t       dat_o,
	output logic                 ack_o,
	output via_pkg::reg_strb_t   reg_wr_o,
	output via_pkg::reg_strb_t   reg_rd_o,
	output via_pkg::data_t       wdata_o,
	output via_pkg::byte_sel_t   wsel_o,
	output via_pkg::data_t       acr_o,
	output via_pkg::data_t       pcr_o,
	input  via_pkg::data_t       pa_rd_i,
	input  via_pkg::data_t       pb_rd_i,
	input  via_pkg::data_t       ddra_i,
	input  via_pkg::data_t       ddrb_i,
	input  via_pkg::data_t       t1_cnt_i,
	input  via_pkg::data_t       t1_lat_i,
	input  via_pkg::data_t       t2_cnt_i,
	input  via_pkg::data_t       t2_lat_i,
	input  via_pkg::data_t       ifr_i,
	input  via_pkg::data_t       ier_i
);

	via_pkg::bus_state_e state;
	via_pkg::reg_strb_t  adr_hot;
	via_pkg::data_t      rd_mux;
	logic                req;

	assign req     = cs_i & cyc_i & stb_i;
	assign adr_hot = via_pkg::reg_strb_t'(1) << adr_i;

	// writes land on the accepting edge and reads strobe in the mux stage
	assign reg_wr_o = (state == via_pkg::BUS_IDLE && req && we_i) ? adr_hot : '0;
	assign reg_rd_o = (state == via_pkg::BUS_RD1) ? adr_hot : '0;
	assign wdata_o  = dat_i;
	assign wsel_o   = sel_i;

	// ======================================================================
	// request FSM
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= via_pkg::BUS_IDLE;
			ack_o <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			case (state)
				via_pkg::BUS_IDLE: begin
					if (req && we_i) begin
						state <= via_pkg::BUS_ACK;
						ack_o <= 1'b1;
					end else if (req) begin
						state <= via_pkg::BUS_RD1;
					end
				end
				via_pkg::BUS_RD1: begin
					state <= via_pkg::BUS_RD2;
					ack_o <= 1'b1; // data registered on this edge
				end
				via_pkg::BUS_RD2: state <= via_pkg::BUS_IDLE;
				via_pkg::BUS_ACK: state <= via_pkg::BUS_IDLE;
				default:          state <= via_pkg::BUS_IDLE;
			endcase
		end
	end

	// configuration registers
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			acr_o <= '0;
			pcr_o <= '0;
		end else begin
			if (reg_wr_o[`VIA_REG_ACR]) acr_o <= via_pkg::byte_merge(acr_o, dat_i, sel_i);
			if (reg_wr_o[`VIA_REG_PCR]) pcr_o <= via_pkg::byte_merge(pcr_o, dat_i, sel_i);
		end
	end

	always_comb begin
		case (adr_i)
			`VIA_REG_PB:   rd_mux = pb_rd_i;
			`VIA_REG_PA:   rd_mux = pa_rd_i;
			`VIA_REG_ORA:  rd_mux = pa_rd_i; // same data without flag clear
			`VIA_REG_DDRB: rd_mux = ddrb_i;
			`VIA_REG_DDRA: rd_mux = ddra_i;
			`VIA_REG_T1CL: rd_mux = t1_cnt_i;
			`VIA_REG_T1LL: rd_mux = t1_lat_i;
			`VIA_REG_T2CL: rd_mux = t2_cnt_i;
			`VIA_REG_T2LL: rd_mux = t2_lat_i;
			`VIA_REG_ACR:  rd_mux = acr_o;
			`VIA_REG_PCR:  rd_mux = pcr_o;
			`VIA_REG_IFR:  rd_mux = ifr_i;
			`VIA_REG_IER:  rd_mux = ier_i;
			default:       rd_mux = '0; // reserved slots
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (state == via_pkg::BUS_RD1) dat_o <= rd_mux;
	end

	a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |=> !ack_o);

endmodule

/* via_port.sv */
// VIA parallel port: direction register, output latch, input latch and control edges
`timescale 1ns/1ns
`include "via_config.svh"

module via_port #(
	parameter int REG_DATA = 0,  // flag-clearing data register
	parameter int REG_DDR  = 2,
	parameter int REG_ALT  = 0,  // alternate data register, 0 for none
	parameter bit MIX_OUT  = 1'b0
) (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  via_pkg::reg_strb_t   reg_wr_i,
	input  via_pkg::reg_strb_t   reg_rd_i,
	input  via_pkg::data_t       wdata_i,
	input  via_pkg::byte_sel_t   wsel_i,
	input  logic                 latch_en_i,
	input  logic                 c1_pol_i,
	input  logic                 c2_pol_i,
	input  via_pkg::data_t       pin_i,
	input  logic                 c1_i,
	input  logic                 c2_i,
	output via_pkg::data_t       pin_o,
	output via_pkg::data_t       pin_oe_o,
	output via_pkg::data_t       rd_o,
	output via_pkg::data_t       ddr_o,
	output logic                 c1_evt_o,
	output logic                 c2_evt_o
);

	via_pkg::data_t ddr, out_q, in_q;
	logic           c1_q, c2_q;
	logic           c1_edge, c2_edge;
	logic           hold;     // latched value waiting to be read
	logic           data_wr, data_rd;

	assign data_wr = reg_wr_i[REG_DATA] || (REG_ALT != 0 && reg_wr_i[REG_ALT]);
	assign data_rd = reg_rd_i[REG_DATA] || (REG_ALT != 0 && reg_rd_i[REG_ALT]);

	// ======================================================================
	// control line edges
	// ======================================================================
	assign c1_edge = c1_pol_i ? (c1_i & ~c1_q) : (~c1_i & c1_q);
	assign c2_edge = c2_pol_i ? (c2_i & ~c2_q) : (~c2_i & c2_q);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			c1_q     <= 1'b0;
			c2_q     <= 1'b0;
			c1_evt_o <= 1'b0;
			c2_evt_o <= 1'b0;
			ddr      <= '0;
			hold     <= 1'b0;
		end else begin
			c1_q     <= c1_i;
			c2_q     <= c2_i;
			c1_evt_o <= c1_edge;
			c2_evt_o <= c2_edge;
			if (reg_wr_i[REG_DDR]) ddr <= via_pkg::byte_merge(ddr, wdata_i, wsel_i);
			if (!latch_en_i || data_rd)
				hold <= 1'b0;
			else if (c1_edge)
				hold <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (data_wr) out_q <= via_pkg::byte_merge(out_q, wdata_i, wsel_i);
		// follow the pins, or capture once per c1 edge when latching
		if (!latch_en_i || (c1_edge && !hold)) in_q <= pin_i;
	end

	assign pin_o    = out_q;
	assign pin_oe_o = ddr;
	assign ddr_o    = ddr;
	assign rd_o     = MIX_OUT ? ((ddr & out_q) | (~ddr & in_q)) : in_q;

	// full-word direction write shows on the enables one clock later
	a_oe_ddr: assert property (@(posedge clk_i) disable iff (rst_i)
		reg_wr_i[REG_DDR] && (&wsel_i) |=> pin_oe_o == $past(wdata_i));

endmodule

/* via_timers.sv */
// VIA interval timers with one-shot/free-run timer 1 and one-shot/pulse-count timer 2
`timescale 1ns/1ns
`include "via_config.svh"

module via_timers (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  via_pkg::reg_strb_t   reg_wr_i,
	input  via_pkg::data_t       wdata_i,
	input  via_pkg::byte_sel_t   wsel_i,
	input  logic                 t1_free_i,
	input  logic                 t2_count_i,
	input  logic                 pb6_i,
	output via_pkg::timer_t      t1_cnt_o,
	output via_pkg::timer_t      t1_lat_o,
	output via_pkg::timer_t      t2_cnt_o,
	output via_pkg::timer_t      t2_lat_o,
	output logic                 t1_evt_o,
	output logic                 t2_evt_o
);

	via_pkg::timer_t t1_cnt, t1_lat, t2_cnt, t2_lat;
	logic            t1_arm, t2_arm;   // one-shot armed by a counter load
	logic            t1_load, t2_load;
	logic            pb6_q, pb6_fall;
	logic            t2_tick;

	assign t1_load  = reg_wr_i[`VIA_REG_T1CL];
	assign t2_load  = reg_wr_i[`VIA_REG_T2CL];
	assign pb6_fall = pb6_q & ~pb6_i;
	assign t2_tick  = t2_count_i ? pb6_fall : 1'b1;

	// zero events taken on the next edge
	assign t1_evt_o = t1_arm && (t1_cnt == '0);
	assign t2_evt_o = t2_arm && (t2_cnt == '0) && t2_tick;

	always_ff @(posedge clk_i) begin
		if (reg_wr_i[`VIA_REG_T1LL]) t1_lat <= via_pkg::byte_merge(t1_lat, wdata_i, wsel_i);
		if (reg_wr_i[`VIA_REG_T2LL]) t2_lat <= via_pkg::byte_merge(t2_lat, wdata_i, wsel_i);
	end

	// ======================================================================
	// timer 1
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			t1_cnt <= '1;
			t1_arm <= 1'b0;
		end else if (t1_load) begin
			t1_cnt <= t1_lat;
			t1_arm <= 1'b1;
		end else if (t1_evt_o && t1_free_i) begin
			t1_cnt <= t1_lat; // free-run reload
		end else begin
			t1_cnt <= t1_cnt - 1'b1; // wraps to all ones after zero
			if (t1_evt_o) t1_arm <= 1'b0;
		end
	end

	// ======================================================================
	// timer 2
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pb6_q  <= 1'b0;
			t2_cnt <= '1;
			t2_arm <= 1'b0;
		end else begin
			pb6_q <= pb6_i;
			if (t2_load) begin
				t2_cnt <= t2_lat;
				t2_arm <= 1'b1;
			end else if (t2_tick) begin
				t2_cnt <= t2_cnt - 1'b1;
				if (t2_evt_o) t2_arm <= 1'b0;
			end
		end
	end

	assign t1_cnt_o = t1_cnt;
	assign t1_lat_o = t1_lat;
	assign t2_cnt_o = t2_cnt;
	assign t2_lat_o = t2_lat;

	// a one-shot fires once per load
	a_t1_once: assert property (@(posedge clk_i) disable iff (rst_i)
		t1_evt_o |=> (!t1_evt_o || t1_free_i || $past(t1_load)));

endmodule

/* via_irq.sv */
// VIA interrupt controller: flag and enable registers, registered interrupt request
`timescale 1ns/1ns
`include "via_config.svh"

module via_irq (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  via_pkg::reg_strb_t   reg_wr_i,
	input  via_pkg::reg_strb_t   reg_rd_i,
	input  via_pkg::data_t       wdata_i,
	input  via_pkg::byte_sel_t   wsel_i,
	input  logic                 ca1_evt_i,
	input  logic                 ca2_evt_i,
	input  logic                 cb1_evt_i,
	input  logic                 cb2_evt_i,
	input  logic                 t1_evt_i,
	input  logic                 t2_evt_i,
	output via_pkg::irq_vec_t    ifr_o,
	output via_pkg::irq_vec_t    ier_o,
	output logic                 irq_o
);

	via_pkg::irq_vec_t flags, set_v, clr_v;
	logic [6:0]        ier;
	logic              pa_acc, pb_acc;

	assign pa_acc = reg_wr_i[`VIA_REG_PA] | reg_rd_i[`VIA_REG_PA];
	assign pb_acc = reg_wr_i[`VIA_REG_PB] | reg_rd_i[`VIA_REG_PB];

	always_comb begin
		set_v = '0; // bit 2 has no source
		set_v[`VIA_IFR_CA2] = ca2_evt_i;
		set_v[`VIA_IFR_CA1] = ca1_evt_i;
		set_v[`VIA_IFR_CB2] = cb2_evt_i;
		set_v[`VIA_IFR_CB1] = cb1_evt_i;
		set_v[`VIA_IFR_T1]  = t1_evt_i;
		set_v[`VIA_IFR_T2]  = t2_evt_i;

		clr_v = '0;
		if (reg_wr_i[`VIA_REG_IFR] && wsel_i[0]) clr_v = wdata_i[7:0];
		if (pa_acc) begin
			clr_v[`VIA_IFR_CA1] = 1'b1;
			clr_v[`VIA_IFR_CA2] = 1'b1;
		end
		if (pb_acc) begin
			clr_v[`VIA_IFR_CB1] = 1'b1;
			clr_v[`VIA_IFR_CB2] = 1'b1;
		end
		if (reg_wr_i[`VIA_REG_T1CL] || reg_rd_i[`VIA_REG_T1CL]) clr_v[`VIA_IFR_T1] = 1'b1;
		if (reg_wr_i[`VIA_REG_T2CL] || reg_rd_i[`VIA_REG_T2CL]) clr_v[`VIA_IFR_T2] = 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			flags <= '0;
			ier   <= '0;
			irq_o <= 1'b0;
		end else begin
			flags <= (flags & ~clr_v) | set_v; // a new event beats a clear
			if (reg_wr_i[`VIA_REG_IER] && wsel_i[0])
				ier <= wdata_i[7] ? (ier | wdata_i[6:0]) : (ier & ~wdata_i[6:0]);
			irq_o <= |(flags[6:0] & ier);
		end
	end

	assign ifr_o = {|(flags[6:0] & ier), flags[6:0]};
	assign ier_o = {1'b0, ier};

endmodule

/* via_top.sv */
// VIA top level: bus slave, two parallel ports, timers and interrupt controller
`timescale 1ns/1ns
`include "via_config.svh"

module via_top (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 cs_i,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic                 we_i,
	input  via_pkg::byte_sel_t   sel_i,
	input  via_pkg::reg_adr_t    adr_i,
	input  via_pkg::data_t       dat_i,
	output via_pkg::data_t       dat_o,
	output logic                 ack_o,
	input  via_pkg::data_t       pa_i,
	input  via_pkg::data_t       pb_i,
	output via_pkg::data_t       pa_o,
	output via_pkg::data_t       pa_oe_o,
	output via_pkg::data_t       pb_o,
	output via_pkg::data_t       pb_oe_o,
	input  logic                 ca1_i,
	input  logic                 ca2_i,
	input  logic                 cb1_i,
	input  logic                 cb2_i,
	output logic                 irq_o
);

	via_pkg::reg_strb_t reg_wr, reg_rd;
	via_pkg::data_t     wdata, acr, pcr, pa_rd, pb_rd, ddra, ddrb;
	via_pkg::byte_sel_t wsel;
	via_pkg::timer_t    t1_cnt, t1_lat, t2_cnt, t2_lat;
	via_pkg::irq_vec_t  ifr, ier;
	logic               ca1_evt, ca2_evt, cb1_evt, cb2_evt, t1_evt, t2_evt;

	via_bus_slave u_bus (
		.clk_i(clk_i), .rst_i(rst_i),
		.cs_i(cs_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
		.sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o),
		.reg_wr_o(reg_wr), .reg_rd_o(reg_rd), .wdata_o(wdata), .wsel_o(wsel),
		.acr_o(acr), .pcr_o(pcr),
		.pa_rd_i(pa_rd), .pb_rd_i(pb_rd), .ddra_i(ddra), .ddrb_i(ddrb),
		.t1_cnt_i(t1_cnt), .t1_lat_i(t1_lat), .t2_cnt_i(t2_cnt), .t2_lat_i(t2_lat),
		.ifr_i({{(`VIA_DW-8){1'b0}}, ifr}), .ier_i({{(`VIA_DW-8){1'b0}}, ier})
	);

	// port A: ORA aliases the data register without flag clears
	via_port #(.REG_DATA(`VIA_REG_PA), .REG_DDR(`VIA_REG_DDRA),
		.REG_ALT(`VIA_REG_ORA), .MIX_OUT(1'b0)) u_port_a (
		.clk_i(clk_i), .rst_i(rst_i),
		.reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .wdata_i(wdata), .wsel_i(wsel),
		.latch_en_i(acr[`VIA_ACR_PA_LE]),
		.c1_pol_i(pcr[`VIA_PCR_CA1_POL]), .c2_pol_i(pcr[`VIA_PCR_CA2_POL]),
		.pin_i(pa_i), .c1_i(ca1_i), .c2_i(ca2_i),
		.pin_o(pa_o), .pin_oe_o(pa_oe_o), .rd_o(pa_rd), .ddr_o(ddra),
		.c1_evt_o(ca1_evt), .c2_evt_o(ca2_evt)
	);

	via_port #(.REG_DATA(`VIA_REG_PB), .REG_DDR(`VIA_REG_DDRB),
		.REG_ALT(0), .MIX_OUT(1'b1)) u_port_b (
		.clk_i(clk_i), .rst_i(rst_i),
		.reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .wdata_i(wdata), .wsel_i(wsel),
		.latch_en_i(acr[`VIA_ACR_PB_LE]),
		.c1_pol_i(pcr[`VIA_PCR_CB1_POL]), .c2_pol_i(pcr[`VIA_PCR_CB2_POL]),
		.pin_i(pb_i), .c1_i(cb1_i), .c2_i(cb2_i),
		.pin_o(pb_o), .pin_oe_o(pb_oe_o), .rd_o(pb_rd), .ddr_o(ddrb),
		.c1_evt_o(cb1_evt), .c2_evt_o(cb2_evt)
	);

	via_timers u_timers (
		.clk_i(clk_i), .rst_i(rst_i),
		.reg_wr_i(reg_wr), .wdata_i(wdata), .wsel_i(wsel),
		.t1_free_i(acr[`VIA_ACR_T1_FREE]), .t2_count_i(acr[`VIA_ACR_T2_CNT]),
		.pb6_i(pb_i[6]),
		.t1_cnt_o(t1_cnt), .t1_lat_o(t1_lat), .t2_cnt_o(t2_cnt), .t2_lat_o(t2_lat),
		.t1_evt_o(t1_evt), .t2_evt_o(t2_evt)
	);

	via_irq u_irq (
		.clk_i(clk_i), .rst_i(rst_i),
		.reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .wdata_i(wdata), .wsel_i(wsel),
		.ca1_evt_i(ca1_evt), .ca2_evt_i(ca2_evt), .cb1_evt_i(cb1_evt), .cb2_evt_i(cb2_evt),
		.t1_evt_i(t1_evt), .t2_evt_i(t2_evt),
		.ifr_o(ifr), .ier_o(ier), .irq_o(irq_o)
	);

endmodule

/* tb_via.sv */
// VIA testbench: drives the bus and pins, checks ports, timers and interrupts against models
`timescale 1ns/1ns
`include "via_config.svh"

module tb_via;

	localparam time CLK_NS = 4;

	logic               clk_i = 1'b0;
	logic               rst_i;
	logic               cs_i, cyc_i, stb_i, we_i;
	via_pkg::byte_sel_t sel_i;
	via_pkg::reg_adr_t  adr_i;
	via_pkg::data_t     dat_i, dat_o, pa_i, pb_i;
	via_pkg::data_t     pa_o, pa_oe_o, pb_o, pb_oe_o;
	logic               ack_o, irq_o, ca1_i, ca2_i, cb1_i, cb2_i;

	logic [31:0]    rng = 32'h324e_9b18;
	via_pkg::data_t exp_ddra = '0; // direction models, updated after each ack
	via_pkg::data_t exp_ddrb = '0;
	via_pkg::data_t exp_ora, exp_orb, wval, latched;
	via_pkg::byte_sel_t rsel;
	int             n_val, k_val;
	time            t_mark;

	via_top u_dut (.*);

	always #(CLK_NS / 2) clk_i = ~clk_i;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// byte lanes with sel set take the new value
	function automatic via_pkg::data_t merge_lanes(input via_pkg::data_t old_v,
		input via_pkg::data_t new_v, input via_pkg::byte_sel_t sel);
		via_pkg::data_t mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_v & ~mask) | (new_v & mask);
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what);
		fail_run($sformatf("Mismatch at %0t ns: %s", $time, what));
	endtask

	// ======================================================================
	// bus access, request held until ack_o
	// ======================================================================
	task automatic access(input logic wr, input via_pkg::reg_adr_t adr,
		input via_pkg::data_t dat, input via_pkg::byte_sel_t sel,
		output via_pkg::data_t rdata);
		int n;
		@(negedge clk_i);
		cs_i  = 1'b1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = wr;
		sel_i = sel;
		adr_i = adr;
		dat_i = dat;
		n = 0;
		@(negedge clk_i);
		while (!ack_o) begin
			if (n == 16) fail_run("bus request got no ack_o within 16 clocks");
			n++;
			@(negedge clk_i);
		end
		rdata = dat_o; // valid while ack_o is high
		stb_i = 1'b0;
		cyc_i = 1'b0;
		cs_i  = 1'b0;
	endtask

	task automatic write_reg(input via_pkg::reg_adr_t adr, input via_pkg::data_t dat,
		input via_pkg::byte_sel_t sel);
		via_pkg::data_t unused;
		access(1'b1, adr, dat, sel, unused);
	endtask

	task automatic read_check(input via_pkg::reg_adr_t adr, input via_pkg::data_t exp,
		input string what);
		via_pkg::data_t got;
		access(1'b0, adr, '0, 4'hf, got);
		assert (got === exp)
			else report_mismatch($sformatf("%s read %h expected %h", what, got, exp));
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge clk_i);
	endtask

	task automatic wait_t1_flag();
		int n;
		n = 0;
		while (!u_dut.u_irq.ifr_o[`VIA_IFR_T1]) begin
			if (n == 1000) fail_run("timer 1 flag not set within 1000 clocks");
			n++;
			@(negedge clk_i);
		end
	endtask

	a_pa_oe: assert property (@(posedge clk_i) disable iff (rst_i) pa_oe_o == exp_ddra)
		else report_mismatch($sformatf("pa_oe_o %h expected %h", pa_oe_o, exp_ddra));
	a_pb_oe: assert property (@(posedge clk_i) disable iff (rst_i) pb_oe_o == exp_ddrb)
		else report_mismatch($sformatf("pb_oe_o %h expected %h", pb_oe_o, exp_ddrb));

	initial begin
		rst_i = 1'b1;
		cs_i  = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
		pa_i  = '0;
		pb_i  = '0;
		ca1_i = 1'b0;
		ca2_i = 1'b0;
		cb1_i = 1'b0;
		cb2_i = 1'b0;
		wait_clocks(3);
		rst_i = 1'b0;
		assert (pa_oe_o === '0 && pb_oe_o === '0 && irq_o === 1'b0)
			else report_mismatch("output enables or irq_o not zero after reset");

		// ======================================================================
		// port A direction and output latch with partial byte writes
		// ======================================================================
		rng = xorshift(rng);
		exp_ora = rng;
		write_reg(`VIA_REG_ORA, exp_ora, 4'hf);
		repeat (4) begin
			rng = xorshift(rng);
			rsel = rng[3:0];
			wval = xorshift(rng ^ 32'h5a5a_0f0f);
			write_reg(`VIA_REG_DDRA, wval, rsel);
			exp_ddra = merge_lanes(exp_ddra, wval, rsel);
			rng = xorshift(rng);
			write_reg(`VIA_REG_ORA, rng, ~rsel);
			exp_ora = merge_lanes(exp_ora, rng, ~rsel);
			assert (pa_o === exp_ora)
				else report_mismatch($sformatf("pa_o %h expected %h", pa_o, exp_ora));
			read_check(`VIA_REG_DDRA, exp_ddra, "DDRA");
		end
		read_check(4'd10, '0, "reserved register");

		// input latching on port A
		rng = xorshift(rng);
		pa_i = rng;
		read_check(`VIA_REG_PA, pa_i, "PA transparent");
		write_reg(`VIA_REG_PCR, 32'h1, 4'hf); // CA1 rising
		write_reg(`VIA_REG_ACR, 32'h1, 4'hf);
		rng = xorshift(rng);
		latched = rng;
		pa_i = latched;
		ca1_i = 1'b1;
		wait_clocks(2);
		rng = xorshift(rng);
		pa_i = rng;
		wait_clocks(2);
		read_check(`VIA_REG_PA, latched, "PA latched on CA1");

		// port B read mix
		rng = xorshift(rng);
		exp_orb = rng;
		write_reg(`VIA_REG_PB, exp_orb, 4'hf);
		rng = xorshift(rng);
		write_reg(`VIA_REG_DDRB, rng, 4'hf);
		exp_ddrb = rng;
		rng = xorshift(rng);
		pb_i = rng;
		read_check(`VIA_REG_PB, (exp_ddrb & exp_orb) | (~exp_ddrb & pb_i), "PB mix");
		assert (pb_o === exp_orb)
			else report_mismatch($sformatf("pb_o %h expected %h", pb_o, exp_orb));

		// ======================================================================
		// timer 1 one-shot and free-run
		// ======================================================================
		rng = xorshift(rng);
		n_val = 8 + int'(rng[3:0]);
		write_reg(`VIA_REG_IER, 32'ha0, 4'h1);
		write_reg(`VIA_REG_T1LL, n_val, 4'hf);
		write_reg(`VIA_REG_T1CL, '0, 4'hf);
		t_mark = $time; // half a clock after the load edge
		wait_t1_flag();
		assert ($time - t_mark == time'(n_val + 1) * CLK_NS)
			else report_mismatch($sformatf("T1 one-shot flag after %0t ns", $time - t_mark));
		assert (irq_o === 1'b0) else report_mismatch("irq_o rose with the T1 flag");
		@(negedge clk_i);
		assert (irq_o === 1'b1) else report_mismatch("irq_o not high one clock after T1 flag");
		write_reg(`VIA_REG_ACR, 32'h40, 4'hf);
		write_reg(`VIA_REG_T1CL, '0, 4'hf);
		wait_t1_flag();
		t_mark = $time;
		write_reg(`VIA_REG_IFR, 32'h20, 4'h1);
		wait_t1_flag();
		assert ($time - t_mark == time'(n_val + 1) * CLK_NS)
			else report_mismatch($sformatf("T1 free-run period %0t ns", $time - t_mark));
		write_reg(`VIA_REG_ACR, '0, 4'hf);
		write_reg(`VIA_REG_T1LL, 32'hffff_ffff, 4'hf); // park timer 1 far from zero
		write_reg(`VIA_REG_T1CL, '0, 4'hf);
		write_reg(`VIA_REG_IFR, 32'h7f, 4'h1);
		write_reg(`VIA_REG_IER, 32'h7f, 4'h1);

		// timer 2 counting pb6 falling edges
		pb_i[6] = 1'b1;
		write_reg(`VIA_REG_ACR, 32'h20, 4'hf);
		rng = xorshift(rng);
		k_val = 2 + int'(rng[2:0]);
		write_reg(`VIA_REG_T2LL, k_val, 4'hf);
		write_reg(`VIA_REG_T2CL, '0, 4'hf);
		for (int i = 1; i <= k_val + 1; i++) begin
			pb_i[6] = 1'b0;
			wait_clocks(2);
			pb_i[6] = 1'b1;
			read_check(`VIA_REG_IFR, (i == k_val + 1) ? 32'h40 : 32'h0, "IFR in pulse count");
		end
		write_reg(`VIA_REG_ACR, '0, 4'hf);
		write_reg(`VIA_REG_IFR, 32'h7f, 4'h1);

		// ======================================================================
		// interrupt enables, CB1 edges and flag clears
		// ======================================================================
		write_reg(`VIA_REG_PCR, 32'h11, 4'hf); // CA1 and CB1 rising
		write_reg(`VIA_REG_IER, 32'h92, 4'h1);
		read_check(`VIA_REG_IER, 32'h12, "IER after set");
		write_reg(`VIA_REG_IER, 32'h02, 4'h1);
		read_check(`VIA_REG_IER, 32'h10, "IER after clear");
		cb1_i = 1'b1;
		wait_clocks(3);
		read_check(`VIA_REG_IFR, 32'h90, "IFR after CB1 rising");
		assert (irq_o === 1'b1) else report_mismatch("irq_o low with enabled CB1 flag");
		read_check(`VIA_REG_PB, (exp_ddrb & exp_orb) | (~exp_ddrb & pb_i), "PB clear read");
		read_check(`VIA_REG_IFR, 32'h0, "IFR after PB read");
		assert (irq_o === 1'b0) else report_mismatch("irq_o high after CB1 flag cleared");
		cb1_i = 1'b0; // wrong polarity
		wait_clocks(3);
		read_check(`VIA_REG_IFR, 32'h0, "IFR after CB1 falling");
		cb1_i = 1'b1;
		ca1_i = 1'b0;
		wait_clocks(2);
		ca1_i = 1'b1;
		wait_clocks(3);
		read_check(`VIA_REG_IFR, 32'h92, "IFR with CA1 and CB1");
		write_reg(`VIA_REG_IFR, 32'h10, 4'h1);
		read_check(`VIA_REG_IFR, 32'h02, "IFR after clearing CB1");
		assert (irq_o === 1'b0) else report_mismatch("irq_o high with no enabled flag");
		write_reg(`VIA_REG_IFR, 32'h02, 4'h1);
		read_check(`VIA_REG_IFR, 32'h0, "IFR after clearing CA1");

		$display("TEST PASS");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
via_pkg.sv
via_bus_slave.sv
via_port.sv
via_timers.sv
via_irq.sv
via_top.sv
tb_via.sv

/* Makefile */
# build and run the VIA testbench with Verilator

sim:
	verilator --binary --timing --assert --top-module tb_via -f tb.f -o tb_via_sim
	./obj_dir/tb_via_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean
